// ==== Makefile ====
TOP := tb_cpu

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

obj_dir/V$(TOP): files.f hdl/*.sv hdl/*.svh bench/*.sv
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// ==== bench/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// ==== bench/tb_cpu.sv ====
`include "cpu_settings.svh"

module tb_cpu import cpu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED = 24520;
    localparam int RUN_TIMEOUT = 5000;
    localparam int RESET_CYCLES = 5;

    // RV32I encodings, PUTC on custom-0
    localparam logic [6:0] OPC_REG = 7'h33;
    localparam logic [6:0] OPC_IMM = 7'h13;
    localparam logic [6:0] OPC_LUI = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;
    localparam logic [6:0] OPC_LOAD = 7'h03;
    localparam logic [6:0] OPC_STORE = 7'h23;
    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam logic [6:0] OPC_JAL = 7'h6f;
    localparam logic [6:0] OPC_JALR = 7'h67;
    localparam logic [6:0] OPC_CUSTOM0 = 7'h0b;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

    logic       clk;
    logic       reset_n;
    prog_load_t load;
    logic       run;
    logic       stdout_valid;
    logic [7:0] stdout_data;
    logic       halted;

    logic [31:0] program_words [$];
    logic [7:0]  expected [$];
    logic [7:0]  expected_head;
    logic        expected_empty;
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [2**`DATA_ADDR_WIDTH];
    string       test_name;
    int          bytes_checked;
    int          value_errors;
    int          other_errors;

    tb_clock clock_gen (.clk(clk));

    cpu_core uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .load        (load),
        .run         (run),
        .stdout_valid(stdout_valid),
        .stdout_data (stdout_data),
        .halted      (halted)
    );

    // Outputs are checked mid-cycle, away from the clock edge
    stdout_value: assert property (@(negedge clk) disable iff (!reset_n)
        stdout_valid && !expected_empty |-> stdout_data == expected_head)
        else begin
            value_errors++;
            $display("Fail %s: expected 0x%02h, actual 0x%02h",
                     test_name, expected_head, stdout_data);
        end

    stdout_wanted: assert property (@(negedge clk) disable iff (!reset_n)
        stdout_valid |-> !expected_empty)
        else begin
            other_errors++;
            $display("%s: byte 0x%02h printed when no more output was expected",
                     test_name, stdout_data);
        end

    quiet_before_run: assert property (@(negedge clk) disable iff (!reset_n)
        !run |-> !stdout_valid && !halted)
        else begin
            other_errors++;
            $display("%s: output or halted seen before run was raised", test_name);
        end

    halted_holds: assert property (@(negedge clk) disable iff (!reset_n)
        halted |=> halted)
        else begin
            other_errors++;
            $display("%s: halted dropped without a reset", test_name);
        end

    quiet_after_halt: assert property (@(negedge clk) disable iff (!reset_n)
        halted |-> !stdout_valid)
        else begin
            other_errors++;
            $display("%s: byte printed after the processor halted", test_name);
        end

    function automatic void refresh_head();
        expected_empty = (expected.size() == 0);
        expected_head = expected_empty ? 8'h00 : expected[0];
    endfunction

    // A byte leaves the queue once its pulse is over
    always @(posedge clk) begin
        if (reset_n && stdout_valid && !expected_empty) begin
            void'(expected.pop_front());
            bytes_checked++;
            refresh_head();
        end
    end

    function automatic logic [31:0] sext12(input int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    function automatic logic [31:0] i_type(input int imm, input int rs1,
                                           input logic [2:0] funct3, input int rd,
                                           input logic [6:0] opcode);
        return {imm[11:0], rs1[4:0], funct3, rd[4:0], opcode};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] funct7, input int rs2,
                                           input int rs1, input logic [2:0] funct3,
                                           input int rd);
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], OPC_REG};
    endfunction

    function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                           input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], funct3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic logic [31:0] putc_word(input int rs1);
        return i_type(0, rs1, 3'b000, 0, OPC_CUSTOM0);
    endfunction

    function automatic int rand12();
        return $urandom % 4096;
    endfunction

    task automatic emit(input logic [31:0] word);
        program_words.push_back(word);
    endtask

    task automatic write_model(input int rd, input logic [31:0] value);
        if (rd != 0) begin
            model_regs[rd] = value;
        end
    endtask

    task automatic expect_byte(input logic [7:0] value);
        expected.push_back(value);
        refresh_head();
    endtask

    task automatic print_reg(input int rs1);
        emit(putc_word(rs1));
        expect_byte(model_regs[rs1][7:0]);
    endtask

    task automatic op_imm(input logic [2:0] funct3, input int rd, input int rs1,
                          input int imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        a = model_regs[rs1];
        b = sext12(imm);
        case (funct3)
            3'b100: result = a ^ b;
            3'b110: result = a | b;
            3'b111: result = a & b;
            default: result = a + b;
        endcase
        emit(i_type(imm, rs1, funct3, rd, OPC_IMM));
        write_model(rd, result);
    endtask

    task automatic op_reg(input logic [6:0] funct7, input logic [2:0] funct3, input int rd,
                          input int rs1, input int rs2);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        a = model_regs[rs1];
        b = model_regs[rs2];
        case (funct3)
            3'b000: result = funct7[5] ? a - b : a + b;
            3'b001: result = a << b[4:0];
            3'b010: result = {31'b0, $signed(a) < $signed(b)};
            3'b100: result = a ^ b;
            3'b101: result = a >> b[4:0];
            3'b110: result = a | b;
            default: result = a & b;
        endcase
        emit(r_type(funct7, rs2, rs1, funct3, rd));
        write_model(rd, result);
    endtask

    task automatic upper_op(input logic [6:0] opcode, input int rd, input int imm20);
        logic [31:0] result;
        result = {imm20[19:0], 12'b0};
        // AUIPC adds its own address
        if (opcode == OPC_AUIPC) begin
            result = result + program_words.size() * 4;
        end
        emit({imm20[19:0], rd[4:0], opcode});
        write_model(rd, result);
    endtask

    task automatic store_word(input int rs2, input int rs1, input int imm);
        logic [31:0] address;
        address = model_regs[rs1] + sext12(imm);
        model_mem[address[`DATA_ADDR_WIDTH+1:2]] = model_regs[rs2];
        emit(s_type(imm, rs2, rs1));
    endtask

    task automatic load_word(input int rd, input int rs1, input int imm);
        logic [31:0] address;
        address = model_regs[rs1] + sext12(imm);
        emit(i_type(imm, rs1, 3'b010, rd, OPC_LOAD));
        write_model(rd, model_mem[address[`DATA_ADDR_WIDTH+1:2]]);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        program_words.delete();
        expected.delete();
        refresh_head();
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
    endtask

    task automatic load_and_run(input int quiet_cycles);
        int cycles;
        @(negedge clk);
        reset_n = 1'b0;
        run = 1'b0;
        load = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        for (int i = 0; i < program_words.size(); i++) begin
            load.enable = 1'b1;
            load.address = i[`PROG_ADDR_WIDTH-1:0];
            load.data = program_words[i];
            @(negedge clk);
        end
        load = '0;
        repeat (10) @(negedge clk);
        run = 1'b1;
        cycles = 0;
        while (!halted && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            other_errors++;
            $display("%s: timed out after %0d cycles waiting for halted", test_name, cycles);
        end else begin
            repeat (quiet_cycles) @(negedge clk);
            all_printed: assert (expected_empty)
                else begin
                    other_errors++;
                    $display("%s: %0d expected bytes were never printed",
                             test_name, expected.size());
                end
        end
    endtask

    task automatic arithmetic_test();
        start_test("arithmetic");
        op_imm(3'b000, 1, 0, rand12());
        op_imm(3'b111, 2, 1, rand12());
        op_imm(3'b110, 3, 1, rand12());
        op_imm(3'b100, 4, 2, rand12());
        op_reg(7'h00, 3'b000, 5, 1, 3);
        op_reg(7'h20, 3'b000, 6, 1, 4);
        op_reg(7'h00, 3'b111, 7, 3, 4);
        op_reg(7'h00, 3'b110, 8, 2, 4);
        op_reg(7'h00, 3'b100, 9, 1, 3);
        op_reg(7'h00, 3'b001, 10, 1, 2);
        op_reg(7'h00, 3'b101, 11, 3, 4);
        op_reg(7'h00, 3'b010, 12, 1, 2);
        op_reg(7'h00, 3'b010, 13, 2, 1);
        for (int r = 1; r <= 13; r++) begin
            print_reg(r);
        end
        // Shift the upper results down so their immediates show up
        op_imm(3'b000, 16, 0, 12);
        upper_op(OPC_LUI, 14, $urandom % 1048576);
        op_reg(7'h00, 3'b101, 15, 14, 16);
        upper_op(OPC_AUIPC, 17, $urandom % 1048576);
        op_reg(7'h00, 3'b101, 18, 17, 16);
        print_reg(14);
        print_reg(15);
        print_reg(17);
        print_reg(18);
        emit(EBREAK_WORD);
        load_and_run(5);
    endtask

    task automatic branch_test();
        start_test("branch");
        emit(i_type(5, 0, 3'b000, 1, OPC_IMM));
        emit(putc_word(1));
        emit(i_type(-1, 1, 3'b000, 1, OPC_IMM));
        emit(b_type(-8, 0, 1, 3'b001));
        emit(i_type('h55, 0, 3'b000, 2, OPC_IMM));
        emit(i_type('h55, 0, 3'b000, 3, OPC_IMM));
        emit(i_type('hee, 0, 3'b000, 4, OPC_IMM));
        // Taken BEQ jumps over the 0xee print
        emit(b_type(8, 3, 2, 3'b000));
        emit(putc_word(4));
        emit(putc_word(2));
        emit(EBREAK_WORD);
        for (int v = 5; v >= 1; v--) begin
            expect_byte(v[7:0]);
        end
        expect_byte(8'h55);
        load_and_run(5);
    endtask

    task automatic memory_test();
        start_test("memory");
        for (int i = 0; i < 4; i++) begin
            op_imm(3'b000, 5 + i, 0, (i * 64 + $urandom % 64) * 4);
            op_imm(3'b000, 9 + i, 0, rand12());
            store_word(9 + i, 5 + i, 0);
        end
        for (int i = 0; i < 4; i++) begin
            load_word(13 + i, 5 + i, 0);
            print_reg(13 + i);
        end
        op_imm(3'b000, 0, 0, 99);
        print_reg(0);
        emit(EBREAK_WORD);
        load_and_run(5);
    endtask

    task automatic jump_test();
        start_test("jump");
        emit(i_type('h53, 0, 3'b000, 10, OPC_IMM));
        emit(i_type('h45, 0, 3'b000, 11, OPC_IMM));
        emit(j_type(16, 1));
        emit(putc_word(1));
        emit(putc_word(11));
        emit(EBREAK_WORD);
        emit(putc_word(10));
        emit(i_type(0, 1, 3'b000, 0, OPC_JALR));
        expect_byte(8'h53);
        // Link is the JAL address 8 plus 4
        expect_byte(8'd12);
        expect_byte(8'h45);
        load_and_run(5);
    endtask

    task automatic halt_test();
        start_test("halt");
        emit(i_type('h21, 0, 3'b000, 1, OPC_IMM));
        emit(putc_word(1));
        emit(EBREAK_WORD);
        emit(putc_word(1));
        emit(putc_word(1));
        expect_byte(8'h21);
        load_and_run(50);
    endtask

    initial begin
        reset_n = 1'b0;
        run = 1'b0;
        load = '0;
        bytes_checked = 0;
        value_errors = 0;
        other_errors = 0;
        test_name = "reset";
        refresh_head();
        void'($urandom(SEED));
        arithmetic_test();
        branch_test();
        memory_test();
        jump_test();
        halt_test();
        $display("Bytes checked: %0d, value errors: %0d, other errors: %0d",
                 bytes_checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/stage_sequencer.sv
hdl/register_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_core.sv
bench/tb_clock.sv
bench/tb_cpu.sv

// ==== hdl/cpu_core.sv ====
`include "cpu_settings.svh"

module cpu_core import cpu_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  prog_load_t load,
    input  logic       run,
    output logic       stdout_valid,
    output logic [7:0] stdout_data,
    output logic       halted
);

    // Fetch, decode, execute, memory, writeback
    logic [4:0]       stage_enable;
    logic             halt_seen;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] fetch_pc;
    instruction_t     instruction;
    decode_out_t      decoded;
    execute_out_t     executed;
    writeback_t       writeback;

    stage_sequencer sequencer (
        .clk         (clk),
        .reset_n     (reset_n),
        .run         (run),
        .halt_seen   (halt_seen),
        .stage_enable(stage_enable),
        .halted      (halted)
    );

    fetch_stage fetch (
        .clk             (clk),
        .reset_n         (reset_n),
        .load            (load),
        .fetch_enable    (stage_enable[0]),
        .writeback_enable(stage_enable[4]),
        .next_pc         (next_pc),
        .instruction     (instruction),
        .pc              (fetch_pc)
    );

    decode_stage decode (
        .clk             (clk),
        .reset_n         (reset_n),
        .decode_enable   (stage_enable[1]),
        .writeback_enable(stage_enable[4]),
        .instruction     (instruction),
        .pc              (fetch_pc),
        .writeback       (writeback),
        .decoded         (decoded)
    );

    execute_stage execute (
        .clk           (clk),
        .reset_n       (reset_n),
        .execute_enable(stage_enable[2]),
        .decoded       (decoded),
        .executed      (executed)
    );

    memory_stage memory (
        .clk          (clk),
        .reset_n      (reset_n),
        .memory_enable(stage_enable[3]),
        .executed     (executed),
        .writeback    (writeback),
        .next_pc      (next_pc),
        .halt_seen    (halt_seen),
        .stdout_valid (stdout_valid),
        .stdout_data  (stdout_data)
    );

endmodule

// ==== hdl/cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

    typedef enum logic [6:0] {
        OP_REG    = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_PUTC   = 7'b0001011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} operand_a_e;
    typedef enum logic [1:0] {OPB_RS2, OPB_IMM, OPB_FOUR} operand_b_e;

    typedef enum logic [1:0] {
        BRANCH_NEVER, BRANCH_EQUAL, BRANCH_NOT_EQUAL, BRANCH_ALWAYS
    } branch_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_format_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_format_t;

    typedef struct packed {
        logic [6:0] imm_high;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_low;
        opcode_e    opcode;
    } s_format_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_format_t;

    // Also carries the scrambled JAL immediate
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_format_t;

    typedef union packed {
        r_format_t r;
        i_format_t i;
        s_format_t s;
        b_format_t b;
        u_format_t u;
    } instruction_t;

    typedef struct packed {
        alu_op_e    alu_op;
        operand_a_e operand_a;
        operand_b_e operand_b;
        branch_e    branch;
        logic       target_from_rs1;
        logic       reg_write;
        logic       mem_to_reg;
        logic       mem_write;
        logic       putc;
        logic       halt;
    } control_t;

    typedef struct packed {
        logic                        enable;
        logic [`PROG_ADDR_WIDTH-1:0] address;
        logic [31:0]                 data;
    } prog_load_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rd;
        control_t         control;
    } decode_out_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [`XLEN-1:0] alu_result;
        logic             zero;
        logic [`XLEN-1:0] target;
        logic [4:0]       rd;
        control_t         control;
    } execute_out_t;

    typedef struct packed {
        logic             enable;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } writeback_t;

endpackage

// ==== hdl/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data word width
`define XLEN 32

// Program memory word address, 256 words
`define PROG_ADDR_WIDTH 8

// Data RAM word address, 256 words
`define DATA_ADDR_WIDTH 8

// First instruction fetched after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== hdl/decode_stage.sv ====
`include "cpu_settings.svh"

module decode_stage import cpu_pkg::*; (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             decode_enable,
    input  logic             writeback_enable,
    input  instruction_t     instruction,
    input  logic [`XLEN-1:0] pc,
    input  writeback_t       writeback,
    output decode_out_t      decoded
);

    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    control_t         control;

    register_file regs (
        .clk           (clk),
        .reset_n       (reset_n),
        .write_enable  (writeback_enable && writeback.enable),
        .write_address (writeback.rd),
        .write_data    (writeback.data),
        .read_address_a(instruction.r.rs1),
        .read_address_b(instruction.r.rs2),
        .read_data_a   (rs1_data),
        .read_data_b   (rs2_data)
    );

    always_comb begin
        control = '0;
        control.alu_op = ALU_ADD;
        control.operand_a = OPA_RS1;
        control.operand_b = OPB_IMM;
        control.branch = BRANCH_NEVER;
        imm = {{20{instruction.i.imm[11]}}, instruction.i.imm};
        case (instruction.r.opcode)
            OP_REG: begin
                control.operand_b = OPB_RS2;
                control.reg_write = 1'b1;
                case (instruction.r.funct3)
                    3'b000: control.alu_op = instruction.r.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001: control.alu_op = ALU_SLL;
                    3'b010: control.alu_op = ALU_SLT;
                    3'b100: control.alu_op = ALU_XOR;
                    3'b101: control.alu_op = ALU_SRL;
                    3'b110: control.alu_op = ALU_OR;
                    default: control.alu_op = ALU_AND;
                endcase
            end
            OP_IMM: begin
                control.reg_write = 1'b1;
                case (instruction.i.funct3)
                    3'b100: control.alu_op = ALU_XOR;
                    3'b110: control.alu_op = ALU_OR;
                    3'b111: control.alu_op = ALU_AND;
                    default: control.alu_op = ALU_ADD;
                endcase
            end
            OP_LUI, OP_AUIPC: begin
                imm = {instruction.u.imm, 12'b0};
                control.reg_write = 1'b1;
                if (instruction.u.opcode == OP_LUI) begin
                    control.operand_a = OPA_ZERO;
                    control.alu_op = ALU_PASS_B;
                end else begin
                    control.operand_a = OPA_PC;
                end
            end
            OP_LOAD: begin
                control.reg_write = 1'b1;
                control.mem_to_reg = 1'b1;
            end
            OP_STORE: begin
                imm = {{20{instruction.s.imm_high[6]}}, instruction.s.imm_high,
                       instruction.s.imm_low};
                control.mem_write = 1'b1;
            end
            OP_BRANCH: begin
                imm = {{19{instruction.b.imm_12}}, instruction.b.imm_12, instruction.b.imm_11,
                       instruction.b.imm_10_5, instruction.b.imm_4_1, 1'b0};
                control.operand_b = OPB_RS2;
                control.alu_op = ALU_SUB;
                control.branch = instruction.b.funct3[0] ? BRANCH_NOT_EQUAL : BRANCH_EQUAL;
            end
            OP_JAL, OP_JALR: begin
                // Link value is pc + 4 from the ALU
                control.operand_a = OPA_PC;
                control.operand_b = OPB_FOUR;
                control.branch = BRANCH_ALWAYS;
                control.reg_write = 1'b1;
                if (instruction.r.opcode == OP_JAL) begin
                    imm = {{11{instruction.u.imm[19]}}, instruction.u.imm[19],
                           instruction.u.imm[7:0], instruction.u.imm[8],
                           instruction.u.imm[18:9], 1'b0};
                end else begin
                    control.target_from_rs1 = 1'b1;
                end
            end
            OP_PUTC: control.putc = 1'b1;
            OP_SYSTEM: control.halt = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            decoded <= '0;
        end else if (decode_enable) begin
            decoded <= '{pc: pc, rs1_data: rs1_data, rs2_data: rs2_data, imm: imm,
                         rd: instruction.r.rd, control: control};
        end
    end

endmodule

// ==== hdl/execute_stage.sv ====
`include "cpu_settings.svh"

module execute_stage import cpu_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  logic         execute_enable,
    input  decode_out_t  decoded,
    output execute_out_t executed
);

    logic [`XLEN-1:0] operand_a;
    logic [`XLEN-1:0] operand_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] target_base;
    logic [`XLEN-1:0] target_sum;

    always_comb begin
        case (decoded.control.operand_a)
            OPA_RS1: operand_a = decoded.rs1_data;
            OPA_PC:  operand_a = decoded.pc;
            default: operand_a = '0;
        endcase
        case (decoded.control.operand_b)
            OPB_RS2:  operand_b = decoded.rs2_data;
            OPB_IMM:  operand_b = decoded.imm;
            default:  operand_b = 'd4;
        endcase
    end

    always_comb begin
        case (decoded.control.alu_op)
            ALU_SUB:    alu_result = operand_a - operand_b;
            ALU_AND:    alu_result = operand_a & operand_b;
            ALU_OR:     alu_result = operand_a | operand_b;
            ALU_XOR:    alu_result = operand_a ^ operand_b;
            ALU_SLL:    alu_result = operand_a << operand_b[4:0];
            ALU_SRL:    alu_result = operand_a >> operand_b[4:0];
            ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
            ALU_PASS_B: alu_result = operand_b;
            default:    alu_result = operand_a + operand_b;
        endcase
    end

    // Second adder for branch and jump targets, bit 0 cleared for JALR
    assign target_base = decoded.control.target_from_rs1 ? decoded.rs1_data : decoded.pc;
    assign target_sum = target_base + decoded.imm;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            executed <= '0;
        end else if (execute_enable) begin
            executed <= '{pc: decoded.pc, rs1_data: decoded.rs1_data,
                          rs2_data: decoded.rs2_data, alu_result: alu_result,
                          zero: (alu_result == '0), target: {target_sum[`XLEN-1:1], 1'b0},
                          rd: decoded.rd, control: decoded.control};
        end
    end

endmodule

// ==== hdl/fetch_stage.sv ====
`include "cpu_settings.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic             clk,
    input  logic             reset_n,
    input  prog_load_t       load,
    input  logic             fetch_enable,
    input  logic             writeback_enable,
    input  logic [`XLEN-1:0] next_pc,
    output instruction_t     instruction,
    output logic [`XLEN-1:0] pc
);

    logic [31:0]      prog_mem [2**`PROG_ADDR_WIDTH];
    logic [`XLEN-1:0] current_pc;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            current_pc <= `RESET_PC;
        end else if (writeback_enable) begin
            current_pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (load.enable && !fetch_enable) begin
            prog_mem[load.address] <= load.data;
        end
    end

    // Word addressed, byte offset dropped
    always_ff @(posedge clk) begin
        if (fetch_enable) begin
            instruction <= prog_mem[current_pc[`PROG_ADDR_WIDTH+1:2]];
            pc <= current_pc;
        end
    end

    no_load_during_fetch: assert property (@(posedge clk) disable iff (!reset_n)
        !(load.enable && fetch_enable))
        else $error("program load during fetch");

endmodule

// ==== hdl/memory_stage.sv ====
`include "cpu_settings.svh"

module memory_stage import cpu_pkg::*; (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             memory_enable,
    input  execute_out_t     executed,
    output writeback_t       writeback,
    output logic [`XLEN-1:0] next_pc,
    output logic             halt_seen,
    output logic             stdout_valid,
    output logic [7:0]       stdout_data
);

    logic [`XLEN-1:0]            data_ram [2**`DATA_ADDR_WIDTH];
    logic [`DATA_ADDR_WIDTH-1:0] ram_address;
    logic [`XLEN-1:0]            load_data;
    logic                        take_branch;

    // Word accesses only
    assign ram_address = executed.alu_result[`DATA_ADDR_WIDTH+1:2];
    assign load_data = data_ram[ram_address];

    always_ff @(posedge clk) begin
        if (memory_enable && executed.control.mem_write) begin
            data_ram[ram_address] <= executed.rs2_data;
        end
    end

    always_comb begin
        case (executed.control.branch)
            BRANCH_EQUAL:     take_branch = executed.zero;
            BRANCH_NOT_EQUAL: take_branch = !executed.zero;
            BRANCH_ALWAYS:    take_branch = 1'b1;
            default:          take_branch = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            writeback <= '0;
            next_pc <= `RESET_PC;
            halt_seen <= 1'b0;
            stdout_valid <= 1'b0;
        end else begin
            stdout_valid <= memory_enable && executed.control.putc;
            if (memory_enable) begin
                writeback.enable <= executed.control.reg_write;
                writeback.rd <= executed.rd;
                writeback.data <= executed.control.mem_to_reg ? load_data : executed.alu_result;
                next_pc <= take_branch ? executed.target : executed.pc + 'd4;
                halt_seen <= executed.control.halt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memory_enable && executed.control.putc) begin
            stdout_data <= executed.rs1_data[7:0];
        end
    end

    // Pulse lands in the cycle after a single-cycle memory enable
    stdout_after_memory: assert property (@(posedge clk) disable iff (!reset_n)
        stdout_valid |-> $past(memory_enable) && !memory_enable)
        else $error("stdout_valid not in the cycle after a single memory enable");

endmodule

// ==== hdl/register_file.sv ====
`include "cpu_settings.svh"

module register_file (
    input  logic             clk,
    input  logic             reset_n,
    input  logic             write_enable,
    input  logic [4:0]       write_address,
    input  logic [`XLEN-1:0] write_data,
    input  logic [4:0]       read_address_a,
    input  logic [4:0]       read_address_b,
    output logic [`XLEN-1:0] read_data_a,
    output logic [`XLEN-1:0] read_data_b
);

    logic [`XLEN-1:0] registers [32];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                registers[i] <= '0;
            end
        end else if (write_enable && write_address != 5'd0) begin
            registers[write_address] <= write_data;
        end
    end

    assign read_data_a = registers[read_address_a];
    assign read_data_b = registers[read_address_b];

    x0_stays_zero: assert property (@(posedge clk) disable iff (!reset_n)
        registers[0] == '0)
        else $error("x0 was written");

endmodule

// ==== hdl/stage_sequencer.sv ====
module stage_sequencer (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       run,
    input  logic       halt_seen,
    output logic [4:0] stage_enable,
    output logic       halted
);

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_RUNNING, SEQ_HALTED} seq_state_e;

    seq_state_e state;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= SEQ_IDLE;
            stage_enable <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (run) begin
                        state <= SEQ_RUNNING;
                        stage_enable <= 5'b00001;
                    end
                end
                SEQ_RUNNING: begin
                    // Writeback of EBREAK ends the run
                    if (stage_enable[4] && halt_seen) begin
                        state <= SEQ_HALTED;
                        stage_enable <= '0;
                    end else begin
                        stage_enable <= {stage_enable[3:0], stage_enable[4]};
                    end
                end
                default: stage_enable <= '0;
            endcase
        end
    end

    assign halted = (state == SEQ_HALTED);

    stage_enable_onehot: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0(stage_enable) && !(halted && |stage_enable))
        else $error("stage_enable not one-hot or active while halted");

endmodule
